//--- busTerm.f
+incdir+common
common/busTermPkg.sv
common/busCycleIf.sv
design/addressDecode.sv
transferAck/romWaitTimer.sv
transferAck/ciaCycleTimer.sv
transferAck/transferAckDrive.sv
design/busTermTop.sv
verif/busTermTb.sv

//--- common/busCycleIf.sv
// All signals change on the rising CLK40 edge. Acknowledge and done strobes last one cycle
`timescale 1ns/100ps
`default_nettype none

interface busCycleIf;

    // Open cycle and its space, held by the decoder
    logic              cycleOpen;
    busTermPkg::spaceT cycleSpace;

    // Single-cycle acknowledge requests from the timers
    logic romAck;
    logic ciaAck;

    // Acknowledge cycle marker from the driver, closes the cycle
    logic cycleDone;

    modport decode (
        output cycleOpen,
        output cycleSpace,
        input  cycleDone
    );

    modport romExec (
        input  cycleOpen,
        input  cycleSpace,
        output romAck
    );

    modport ciaExec (
        input  cycleOpen,
        input  cycleSpace,
        output ciaAck
    );

    modport result (
        input  romAck,
        input  ciaAck,
        input  cycleSpace,
        output cycleDone
    );

endinterface

`default_nettype wire

//--- common/busTermPkg.sv
// Shared types only. Addresses are 32 bits and the ROM wait counter holds at most 7 cycles
`default_nettype none

package busTermPkg;

    //////////////////////////////
    // Bus vectors
    //////////////////////////////

    // Full 68040 address as presented with ts
    typedef logic [31:0] addrT;

    // Decoded address space, one of the SPACE_ codes
    typedef logic [1:0] spaceT;

    // ROM setup wait counter
    typedef logic [2:0] waitCountT;

    //////////////////////////////
    // CIA timer states
    //////////////////////////////

    // Idle until a CIA cycle is armed, then high phase, low phase, acknowledge
    typedef enum logic [1:0] {
        stIdle,
        stWaitHigh,
        stWaitLow,
        stAck
    } ciaStateT;

endpackage

`default_nettype wire

//--- common/busTerm_defines.svh
// Windows must not overlap and ROM_WAIT_CYCLES must stay between 1 and 7 to fit the counter
`ifndef BUSTERM_DEFINES_SVH
`define BUSTERM_DEFINES_SVH

//////////////////////////////
// Address map
//////////////////////////////

// 512 KB boot ROM window ending at 16 MB
`define ROM_BASE 32'h00F8_0000
`define ROM_MASK 32'hFFF8_0000

// 64 KB CIA register window
`define CIA_BASE 32'h00BF_0000
`define CIA_MASK 32'hFFFF_0000

//////////////////////////////
// Timing
//////////////////////////////

// CLK40 edges from cycle start to the ROM acknowledge pulse
// Covers ROM access and data setup time
`define ROM_WAIT_CYCLES 3

//////////////////////////////
// Space codes
//////////////////////////////

// Unmapped space belongs to another responder
`define SPACE_NONE 2'd0
`define SPACE_ROM  2'd1
`define SPACE_CIA  2'd2

`endif

//--- design/addressDecode.sv
// ts is a one-cycle strobe with addr valid alongside. A ts during an open or guard cycle is dropped
`timescale 1ns/100ps
`default_nettype none
`include "busTerm_defines.svh"

module addressDecode (
    input  logic             CLK40,
    input  logic             nRESET,
    input  logic             ts,
    input  busTermPkg::addrT addr,
    output logic             nRomEn,
    output logic             nCiaCs,
    busCycleIf.decode        cyc
);

    logic              romHit;
    logic              ciaHit;
    logic              tsAccept;
    logic              trailing;
    busTermPkg::spaceT nextSpace;

    //////////////////////////////
    // Address compare
    //////////////////////////////

    // Only the masked upper bits select a window
    assign romHit = (addr & `ROM_MASK) == `ROM_BASE;
    assign ciaHit = (addr & `CIA_MASK) == `CIA_BASE;

    // ROM takes priority if the map is ever edited into an overlap
    always_comb begin
        if (romHit) begin
            nextSpace = `SPACE_ROM;
        end else if (ciaHit) begin
            nextSpace = `SPACE_CIA;
        end else begin
            nextSpace = `SPACE_NONE;
        end
    end

    // Start of a new cycle
    // Blocked through the acknowledge and guard cycles
    assign tsAccept = ts && !cyc.cycleOpen && !trailing;

    //////////////////////////////
    // Cycle state and selects
    //////////////////////////////

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            cyc.cycleOpen  <= 1'b0;
            cyc.cycleSpace <= `SPACE_NONE;
            nRomEn         <= 1'b1;
            nCiaCs         <= 1'b1;
            trailing       <= 1'b0;
        end else begin
            // Guard cycle follows the acknowledge cycle
            trailing <= cyc.cycleDone;
            if (cyc.cycleDone) begin
                // Acknowledge seen, deselect on this edge
                cyc.cycleOpen <= 1'b0;
                nRomEn        <= 1'b1;
                nCiaCs        <= 1'b1;
            end else if (tsAccept) begin
                cyc.cycleSpace <= nextSpace;
                // Unmapped space stays closed and silent
                cyc.cycleOpen  <= (nextSpace != `SPACE_NONE);
                nRomEn         <= (nextSpace != `SPACE_ROM);
                nCiaCs         <= (nextSpace != `SPACE_CIA);
            end
        end
    end

    // Processor must wait for taOe to fall before the next ts
    tsWhileBusy: assert property (@(posedge CLK40) disable iff (!nRESET)
        ts |-> !(cyc.cycleOpen || trailing))
        else $error("ts seen while a bus cycle is still open");

endmodule

`default_nettype wire

//--- design/busTermTop.sv
// Tristate pins are split into level outputs plus taOe. No data path or arbitration
`timescale 1ns/100ps
`default_nettype none

module busTermTop (
    input  logic             CLK40,
    input  logic             nRESET,
    input  logic             ts,
    input  busTermPkg::addrT addr,
    input  logic             clkCia,
    output logic             nRomEn,
    output logic             nCiaCs,
    output logic             nTa,
    output logic             nTbi,
    output logic             nTci,
    output logic             taOe
);

    //////////////////////////////
    // Cycle bus
    //////////////////////////////

    busCycleIf cycIf ();

    //////////////////////////////
    // Decode
    //////////////////////////////

    addressDecode decode0 (
        .CLK40  (CLK40),
        .nRESET (nRESET),
        .ts     (ts),
        .addr   (addr),
        .nRomEn (nRomEn),
        .nCiaCs (nCiaCs),
        .cyc    (cycIf.decode)
    );

    //////////////////////////////
    // Timers
    //////////////////////////////

    romWaitTimer romTimer0 (
        .CLK40  (CLK40),
        .nRESET (nRESET),
        .cyc    (cycIf.romExec)
    );

    // Only this path sees the slow CIA clock
    ciaCycleTimer ciaTimer0 (
        .CLK40  (CLK40),
        .nRESET (nRESET),
        .clkCia (clkCia),
        .cyc    (cycIf.ciaExec)
    );

    //////////////////////////////
    // Acknowledge outputs
    //////////////////////////////

    transferAckDrive ackDrive0 (
        .CLK40  (CLK40),
        .nRESET (nRESET),
        .nTa    (nTa),
        .nTbi   (nTbi),
        .nTci   (nTci),
        .taOe   (taOe),
        .cyc    (cycIf.result)
    );

endmodule

`default_nettype wire

//--- runSim.sh
#!/bin/sh
# Build and run the bus termination testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f busTerm.f --top-module busTermTb -o busTermSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/busTermSim)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx '=== PASS ==='; then
    exit 0
fi
echo "Simulation did not report success"
exit 1

//--- transferAck/ciaCycleTimer.sv
// clkCia is asynchronous and must be slower than CLK40/2. Latency follows the CIA clock phase
`timescale 1ns/100ps
`default_nettype none
`include "busTerm_defines.svh"

module ciaCycleTimer (
    input  logic       CLK40,
    input  logic       nRESET,
    input  logic       clkCia,
    busCycleIf.ciaExec cyc
);

    logic                 ciaSync0;
    logic                 ciaSync1;
    logic                 ciaCycle;
    logic                 ciaArmed;
    busTermPkg::ciaStateT state;

    // Open CIA cycle
    assign ciaCycle = cyc.cycleOpen && (cyc.cycleSpace == `SPACE_CIA);

    //////////////////////////////
    // CIA clock synchronizer
    //////////////////////////////

    // Two flops against metastability
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            ciaSync0 <= 1'b0;
            ciaSync1 <= 1'b0;
        end else begin
            ciaSync0 <= clkCia;
            ciaSync1 <= ciaSync0;
        end
    end

    // Open flag delayed by one edge
    // Matches the synchronizer lag so only samples taken after the open count
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            ciaArmed <= 1'b0;
        end else begin
            ciaArmed <= ciaCycle;
        end
    end

    //////////////////////////////
    // Termination FSM
    //////////////////////////////

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            state      <= busTermPkg::stIdle;
            cyc.ciaAck <= 1'b0;
        end else begin
            cyc.ciaAck <= 1'b0;
            if (!ciaCycle) begin
                state <= busTermPkg::stIdle;
            end else begin
                case (state)
                    busTermPkg::stIdle: begin
                        if (ciaArmed) begin
                            state <= busTermPkg::stWaitHigh;
                        end
                    end
                    // CIA clock must be seen high first
                    busTermPkg::stWaitHigh: begin
                        if (ciaSync1) begin
                            state <= busTermPkg::stWaitLow;
                        end
                    end
                    // Falling edge of the CIA clock ends the access
                    busTermPkg::stWaitLow: begin
                        if (!ciaSync1) begin
                            state      <= busTermPkg::stAck;
                            cyc.ciaAck <= 1'b1;
                        end
                    end
                    // Parked until the decoder closes the cycle
                    busTermPkg::stAck: begin
                        state <= busTermPkg::stAck;
                    end
                    default: begin
                        state <= busTermPkg::stIdle;
                    end
                endcase
            end
        end
    end

    // Acknowledge only inside the CIA cycle that the decoder holds open
    ciaAckInCycle: assert property (@(posedge CLK40) disable iff (!nRESET)
        cyc.ciaAck |-> (cyc.cycleOpen && cyc.cycleSpace == `SPACE_CIA))
        else $error("ciaAck outside an open CIA cycle");

endmodule

`default_nettype wire

//--- transferAck/romWaitTimer.sv
// ROM acknowledge pulses ROM_WAIT_CYCLES edges after ts. One pulse per cycle, no early abort
`timescale 1ns/100ps
`default_nettype none
`include "busTerm_defines.svh"

module romWaitTimer (
    input  logic       CLK40,
    input  logic       nRESET,
    busCycleIf.romExec cyc
);

    // Count at which the pulse is issued
    // The decoder registers the open one edge after ts, so the count starts there
    localparam busTermPkg::waitCountT waitLast = busTermPkg::waitCountT'(`ROM_WAIT_CYCLES - 1);
    // Terminal count, held until the cycle closes
    localparam busTermPkg::waitCountT waitDone = busTermPkg::waitCountT'(`ROM_WAIT_CYCLES);

    logic                  romCycle;
    busTermPkg::waitCountT waitCount;

    // Open ROM cycle
    assign romCycle = cyc.cycleOpen && (cyc.cycleSpace == `SPACE_ROM);

    //////////////////////////////
    // Setup wait counter
    //////////////////////////////

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            waitCount  <= '0;
            cyc.romAck <= 1'b0;
        end else begin
            // Pulse by default lasts one cycle
            cyc.romAck <= 1'b0;
            if (!romCycle) begin
                // Rearm once the cycle has closed
                waitCount <= '0;
            end else if (waitCount != waitDone) begin
                waitCount <= waitCount + 1'b1;
                // Last step of the wait
                if (waitCount == waitLast) begin
                    cyc.romAck <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- transferAck/transferAckDrive.sv
// taOe stands in for the tristate enable. The acknowledge pulses never coincide
`timescale 1ns/100ps
`default_nettype none
`include "busTerm_defines.svh"

module transferAckDrive (
    input  logic      CLK40,
    input  logic      nRESET,
    output logic      nTa,
    output logic      nTbi,
    output logic      nTci,
    output logic      taOe,
    busCycleIf.result cyc
);

    logic ackPulse;
    logic ciaSpace;

    // Either timer ends the cycle
    assign ackPulse = cyc.romAck || cyc.ciaAck;

    // Peripheral registers must never be cached
    assign ciaSpace = (cyc.cycleSpace == `SPACE_CIA);

    //////////////////////////////
    // Acknowledge and guard
    //////////////////////////////

    // Cycle 1 drives the acknowledge low
    // Cycle 2 drives it high to beat down ringing on the line
    // Cycle 3 releases
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            nTa           <= 1'b1;
            nTbi          <= 1'b1;
            nTci          <= 1'b1;
            taOe          <= 1'b0;
            cyc.cycleDone <= 1'b0;
        end else begin
            nTa           <= !ackPulse;
            // No bursts from ROM or CIA
            nTbi          <= !ackPulse;
            nTci          <= !(ackPulse && ciaSpace);
            // Enable covers the acknowledge and the guard cycle after it
            taOe          <= ackPulse || !nTa;
            // Decoder closes the cycle on the next edge
            cyc.cycleDone <= ackPulse;
        end
    end

    // Only one space can be open, so only one timer may answer
    oneAckSource: assert property (@(posedge CLK40) disable iff (!nRESET)
        !(cyc.romAck && cyc.ciaAck))
        else $error("ROM and CIA acknowledge in the same cycle");

    // A low acknowledge must always be driven
    taDrivenWhenLow: assert property (@(posedge CLK40) disable iff (!nRESET)
        !nTa |-> taOe)
        else $error("nTa low while the driver is released");

endmodule

`default_nettype wire

//--- verif/busTermTb.sv
// Run from the project root so the vector file is found. CIA half-periods below 2 are raised to 2
`timescale 1ns/100ps
`default_nettype none
`include "busTerm_defines.svh"

module busTermTb;

    // Vector lines hold four words each
    localparam int maxTests = 32;

    logic             CLK40;
    logic             nRESET;
    logic             ts;
    busTermPkg::addrT addr;
    logic             clkCia;
    logic             nRomEn;
    logic             nCiaCs;
    logic             nTa;
    logic             nTbi;
    logic             nTci;
    logic             taOe;
    logic [31:0]      vecMem [0:maxTests*4-1];
    int               seed;
    int               ciaHalf;
    int               ciaCount;
    logic             ciaAtEdge;
    int               errorCount;
    int               passCount;
    int               failCount;
    bit               hung;
    string            testName;

    busTermTop dut0 (.*);

    // 40 ns period
    always #20 CLK40 = ~CLK40;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("ERROR %s %s expected %0h actual %0h", testName, what, expected, actual);
        end
    endtask

    // All stimulus moves on the falling edge, the CIA clock included
    task automatic nextFall();
        @(negedge CLK40);
        // Level that the rising edge just before saw
        ciaAtEdge = clkCia;
        ciaCount++;
        if (ciaCount >= ciaHalf) begin
            ciaCount = 0;
            clkCia   = ~clkCia;
        end
    endtask

    // Space that the address map gives an address
    function automatic logic [1:0] mapSpace(input logic [31:0] a);
        return ((a & `ROM_MASK) == `ROM_BASE) ? `SPACE_ROM :
               ((a & `CIA_MASK) == `CIA_BASE) ? `SPACE_CIA : `SPACE_NONE;
    endfunction

    // Chip selects low only for the open space
    task automatic checkSelects(input string what, input logic [1:0] space, input bit open);
        checkValue({what, " nRomEn"}, 32'(!(open && space == `SPACE_ROM)), 32'(nRomEn));
        checkValue({what, " nCiaCs"}, 32'(!(open && space == `SPACE_CIA)), 32'(nCiaCs));
    endtask

    task automatic recordResult(input int startErrors);
        if (!hung && errorCount == startErrors) begin
            passCount++;
            $display("%s ok", testName);
        end else begin
            failCount++;
            $display("%s failed", testName);
        end
    endtask

    //////////////////////////////
    // Bus cycles
    //////////////////////////////

    // k counts rising edges after E0, outputs read at the falling edge after each
    task automatic runMapped(input logic [1:0] space);
        int k;
        int eu;
        bit seenHigh;
        bit isCia;
        isCia    = (space == `SPACE_CIA);
        k        = 0;
        eu       = -1;
        seenHigh = 1'b0;
        nextFall();
        ts = 1'b0;
        while (nTa && k < 4 * ciaHalf + 20) begin
            checkSelects("open", space, 1'b1);
            checkValue("taOe open", 0, 32'(taOe));
            // Only samples after the opening edge count for the CIA clock
            if (k > 0 && !seenHigh && ciaAtEdge) begin
                seenHigh = 1'b1;
            end else if (k > 0 && seenHigh && !ciaAtEdge && eu < 0) begin
                eu = k;
            end
            nextFall();
            k++;
        end
        if (nTa) begin
            $display("Timeout: %s got no transfer acknowledge after %0d cycles", testName, k);
            hung = 1'b1;
        end else begin
            // CIA acks 3 edges after Eu, ROM after the fixed wait plus the output register
            checkValue("ack edge", isCia ? 32'(eu + 3) : `ROM_WAIT_CYCLES + 1, 32'(k));
            checkValue("nTbi ack", 0, 32'(nTbi));
            checkValue("nTci ack", isCia ? 0 : 1, 32'(nTci));
            checkValue("taOe ack", 1, 32'(taOe));
            checkSelects("ack", space, 1'b1);
            // Overdrive guard cycle
            nextFall();
            checkValue("nTa guard", 1, 32'(nTa));
            checkValue("nTbi guard", 1, 32'(nTbi));
            checkValue("nTci guard", 1, 32'(nTci));
            checkValue("taOe guard", 1, 32'(taOe));
            checkSelects("guard", space, 1'b0);
            // Line released, next ts may follow right here
            nextFall();
            checkValue("taOe release", 0, 32'(taOe));
            checkSelects("release", space, 1'b0);
        end
    endtask

    task automatic runTest(input int idx);
        logic [31:0] half;
        logic [1:0]  space;
        int          startErrors;
        int          phase;
        testName    = $sformatf("test%02h", vecMem[idx*4][7:0]);
        half        = vecMem[idx*4+2];
        space       = vecMem[idx*4+3][1:0];
        startErrors = errorCount;
        // Vector table must agree with the address map
        checkValue("space code", vecMem[idx*4+3], 32'(mapSpace(vecMem[idx*4+1])));
        // New CIA rate and a random phase for each cycle
        phase    = $random(seed);
        ciaHalf  = (half < 2) ? 2 : int'(half);
        ciaCount = int'($unsigned(phase) % ciaHalf);
        clkCia   = phase[16];
        ts       = 1'b1;
        addr     = vecMem[idx*4+1];
        if (space == `SPACE_NONE) begin
            nextFall();
            ts = 1'b0;
            // Another responder owns this address
            repeat (20) begin
                checkSelects("unmapped", space, 1'b0);
                checkValue("taOe unmapped", 0, 32'(taOe));
                nextFall();
            end
        end else begin
            runMapped(space);
        end
        recordResult(startErrors);
    endtask

    initial begin
        int idx;
        int startErrors;
        CLK40      = 1'b0;
        nRESET     = 1'b0;
        ts         = 1'b0;
        addr       = '0;
        clkCia     = 1'b0;
        seed       = 32'h61b8_482a;
        ciaHalf    = 3;
        ciaCount   = 0;
        ciaAtEdge  = 1'b0;
        errorCount = 0;
        passCount  = 0;
        failCount  = 0;
        hung       = 1'b0;
        $readmemh("verif/busTermVectors.txt", vecMem);
        // Two rising edges under reset
        nextFall();
        nextFall();
        nRESET = 1'b1;
        nextFall();
        testName    = "reset";
        startErrors = errorCount;
        checkValue("taOe", 0, 32'(taOe));
        checkValue("nTa", 1, 32'(nTa));
        checkValue("nTbi", 1, 32'(nTbi));
        checkValue("nTci", 1, 32'(nTci));
        checkSelects("idle", `SPACE_NONE, 1'b0);
        recordResult(startErrors);
        idx = 0;
        // Id 00 or FF ends the list
        while (!hung && idx < maxTests && vecMem[idx*4][7:0] != 8'h00
               && vecMem[idx*4][7:0] != 8'hFF) begin
            runTest(idx);
            idx++;
        end
        if (idx == 0) begin
            $display("No test vectors were read");
        end
        $display("tests passed %0d failed %0d", passCount, failCount);
        if (failCount == 0 && !hung && idx > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/busTermVectors.txt
// id  address   CIA half-period (CLK40 cycles)  expected space (0 none, 1 ROM, 2 CIA)
// Lines run back to back, id FF ends the list
01 00F80000 3 1
02 00BFE001 4 2
03 00FFFFFC 2 1
04 00BFD100 2 2
05 00BF0000 7 2
06 00C00000 3 0
07 00F80400 5 1
08 00BFE201 3 2
09 00BEFFFF 4 0
0A 00FC0000 6 1
0B 00BFFFFE 5 2
0C 00F7FFFC 3 0
0D 01F80000 4 0
0E 00BFEC01 2 2
0F 00F81000 3 1
10 00BFE301 6 2
11 00000000 3 0
12 00FA0000 4 1
13 00BF4000 3 2
FF 00000000 0 0
